/* rtl/noc_defines.svh */
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// Mesh dimensions
`define NOC_MESH_X 4
`define NOC_MESH_Y 4
`define NOC_NODES (`NOC_MESH_X * `NOC_MESH_Y)

// One coordinate field of the header
`define NOC_COORD_W 2

// Single-flit packet width
`define NOC_FLIT_W 64

`endif

/* rtl/noc_pkg.sv */
`include "noc_defines.svh"

package noc_pkg;

  localparam int num_ports = 5;  // Local plus four neighbors

  // Payload fills whatever the four header fields leave
  localparam int payload_w = `NOC_FLIT_W - 4 * `NOC_COORD_W;

  typedef logic [`NOC_COORD_W-1:0] coord_t;

  // Header sits in the top bits, destination first
  typedef struct packed {
    coord_t                 dst_x;
    coord_t                 dst_y;
    coord_t                 src_x;
    coord_t                 src_y;
    logic [payload_w-1:0]   payload;
  } flit_t;

  // North is towards increasing y, east towards increasing x
  typedef enum logic [2:0] {
    port_local,
    port_north,
    port_south,
    port_east,
    port_west
  } port_e;

  // One bit per port_e, used for requests and grants
  typedef logic [num_ports-1:0] port_vec_t;

endpackage

/* rtl/noc_input_port.sv */
module noc_input_port import noc_pkg::*; #(
  parameter int unsigned x_pos = 0,
  parameter int unsigned y_pos = 0
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      send,
  input  flit_t     flit,
  input  logic      grant,
  output logic      ready,
  output port_vec_t req,
  output flit_t     held_flit
);

  localparam coord_t here_x = coord_t'(x_pos);
  localparam coord_t here_y = coord_t'(y_pos);

  logic  empty_q;  // Buffer state, also the link ready
  port_e route;
  logic  accept;

  assign accept = send && empty_q;
  assign ready  = empty_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      empty_q <= 1'b1;
    end else if (accept) begin
      empty_q <= 1'b0;
    end else if (grant) begin
      empty_q <= 1'b1;  // Flit moves into the output register
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held_flit <= flit;
    end
  end

  // Dimension-ordered routing, X is resolved before Y
  always_comb begin
    if (held_flit.dst_x > here_x) begin
      route = port_east;
    end else if (held_flit.dst_x < here_x) begin
      route = port_west;
    end else if (held_flit.dst_y > here_y) begin
      route = port_north;
    end else if (held_flit.dst_y < here_y) begin
      route = port_south;
    end else begin
      route = port_local;  // Arrived
    end
  end

  // One-hot request only while a flit is held
  assign req = empty_q ? '0 : (port_vec_t'(1) << route);

endmodule

/* rtl/noc_output_port.sv */
module noc_output_port import noc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  port_vec_t req,
  input  flit_t     flits [num_ports],
  input  logic      ready,
  output port_vec_t grant,
  output logic      send,
  output flit_t     flit
);

  logic       full_q;
  port_e      ptr_q;    // Requester with the highest priority
  logic [2:0] sel_idx;  // Winner of the current scan
  logic       any_req;

  // Scan the five requesters starting at the pointer, wrapping at the end
  always_comb begin
    int idx;
    grant   = '0;
    sel_idx = ptr_q;
    any_req = 1'b0;
    for (int k = 0; k < num_ports; k++) begin
      idx = int'(ptr_q) + k;
      if (idx >= num_ports) begin
        idx = idx - num_ports;
      end
      if (!any_req && req[idx]) begin
        any_req = 1'b1;
        sel_idx = idx[2:0];
      end
    end
    // Only an empty register takes a new flit
    if (!full_q && any_req) begin
      grant[sel_idx] = 1'b1;
    end
  end

  assign send = full_q && ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
      ptr_q  <= port_local;
    end else if (|grant) begin
      full_q <= 1'b1;
      // Next scan starts one past the winner
      ptr_q  <= (sel_idx == 3'(num_ports - 1)) ? port_local : port_e'(sel_idx + 3'd1);
    end else if (send) begin
      full_q <= 1'b0;  // Downstream buffer takes it at this edge
    end
  end

  always_ff @(posedge clk) begin
    if (|grant) begin
      flit <= flits[sel_idx];
    end
  end

endmodule

/* rtl/noc_router.sv */
module noc_router import noc_pkg::*; #(
  parameter int unsigned x_pos = 0,
  parameter int unsigned y_pos = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [num_ports-1:0] in_send,
  input  flit_t                in_flit   [num_ports],
  input  logic [num_ports-1:0] out_ready,
  output logic [num_ports-1:0] in_ready,
  output logic [num_ports-1:0] out_send,
  output flit_t                out_flit  [num_ports]
);

  port_vec_t            in_req  [num_ports];  // Indexed by input, one bit per output
  port_vec_t            out_req [num_ports];  // Indexed by output, one bit per input
  port_vec_t            out_gnt [num_ports];  // Indexed by output, one bit per input
  logic [num_ports-1:0] in_gnt;
  flit_t                held    [num_ports];

  for (genvar p = 0; p < num_ports; p++) begin : g_port
    noc_input_port #(
      .x_pos (x_pos),
      .y_pos (y_pos)
    ) in_port_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .send      (in_send[p]),
      .flit      (in_flit[p]),
      .grant     (in_gnt[p]),
      .ready     (in_ready[p]),
      .req       (in_req[p]),
      .held_flit (held[p])
    );

    // Every output sees all held flits and picks by grant
    noc_output_port out_port_i (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (out_req[p]),
      .flits (held),
      .ready (out_ready[p]),
      .grant (out_gnt[p]),
      .send  (out_send[p]),
      .flit  (out_flit[p])
    );
  end

  // Crossbar of requests, input-major to output-major
  always_comb begin
    for (int o = 0; o < num_ports; o++) begin
      for (int i = 0; i < num_ports; i++) begin
        out_req[o][i] = in_req[i][o];
      end
    end
  end

  // An input requests a single output, so at most one grant bit reaches it
  always_comb begin
    in_gnt = '0;
    for (int o = 0; o < num_ports; o++) begin
      for (int i = 0; i < num_ports; i++) begin
        in_gnt[i] = in_gnt[i] | out_gnt[o][i];
      end
    end
  end

endmodule

/* rtl/noc_mesh.sv */
`include "noc_defines.svh"

module noc_mesh import noc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`NOC_NODES-1:0] nic_in_send,
  input  flit_t                 nic_in_flit  [`NOC_NODES],
  output logic [`NOC_NODES-1:0] nic_in_ready,
  output logic [`NOC_NODES-1:0] nic_out_send,
  output flit_t                 nic_out_flit [`NOC_NODES],
  input  logic [`NOC_NODES-1:0] nic_out_ready
);

  // Router-side views of every port, node index first
  logic [num_ports-1:0] in_send   [`NOC_NODES];
  flit_t                in_flit   [`NOC_NODES][num_ports];
  logic [num_ports-1:0] in_ready  [`NOC_NODES];
  logic [num_ports-1:0] out_send  [`NOC_NODES];
  flit_t                out_flit  [`NOC_NODES][num_ports];
  logic [num_ports-1:0] out_ready [`NOC_NODES];

  // Node (0,0) is the south-west corner, y grows northwards
  for (genvar y = 0; y < `NOC_MESH_Y; y++) begin : g_row
    for (genvar x = 0; x < `NOC_MESH_X; x++) begin : g_col
      localparam int n = y * `NOC_MESH_X + x;

      noc_router #(
        .x_pos (x),
        .y_pos (y)
      ) router_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_send   (in_send[n]),
        .in_flit   (in_flit[n]),
        .out_ready (out_ready[n]),
        .in_ready  (in_ready[n]),
        .out_send  (out_send[n]),
        .out_flit  (out_flit[n])
      );

      assign in_send[n][port_local]   = nic_in_send[n];
      assign in_flit[n][port_local]   = nic_in_flit[n];
      assign nic_in_ready[n]          = in_ready[n][port_local];
      assign nic_out_send[n]          = out_send[n][port_local];
      assign nic_out_flit[n]          = out_flit[n][port_local];
      assign out_ready[n][port_local] = nic_out_ready[n];

      if (y < `NOC_MESH_Y - 1) begin : g_north
        assign in_send[n][port_north]   = out_send[n + `NOC_MESH_X][port_south];
        assign in_flit[n][port_north]   = out_flit[n + `NOC_MESH_X][port_south];
        assign out_ready[n][port_north] = in_ready[n + `NOC_MESH_X][port_south];
      end else begin : g_north_edge
        assign in_send[n][port_north]   = 1'b0;
        assign in_flit[n][port_north]   = '0;
        assign out_ready[n][port_north] = 1'b0;
      end

      if (y > 0) begin : g_south
        assign in_send[n][port_south]   = out_send[n - `NOC_MESH_X][port_north];
        assign in_flit[n][port_south]   = out_flit[n - `NOC_MESH_X][port_north];
        assign out_ready[n][port_south] = in_ready[n - `NOC_MESH_X][port_north];
      end else begin : g_south_edge
        assign in_send[n][port_south]   = 1'b0;
        assign in_flit[n][port_south]   = '0;
        assign out_ready[n][port_south] = 1'b0;
      end

      if (x < `NOC_MESH_X - 1) begin : g_east
        assign in_send[n][port_east]   = out_send[n + 1][port_west];
        assign in_flit[n][port_east]   = out_flit[n + 1][port_west];
        assign out_ready[n][port_east] = in_ready[n + 1][port_west];
      end else begin : g_east_edge
        assign in_send[n][port_east]   = 1'b0;
        assign in_flit[n][port_east]   = '0;
        assign out_ready[n][port_east] = 1'b0;
      end

      if (x > 0) begin : g_west
        assign in_send[n][port_west]   = out_send[n - 1][port_east];
        assign in_flit[n][port_west]   = out_flit[n - 1][port_east];
        assign out_ready[n][port_west] = in_ready[n - 1][port_east];
      end else begin : g_west_edge
        assign in_send[n][port_west]   = 1'b0;
        assign in_flit[n][port_west]   = '0;
        assign out_ready[n][port_west] = 1'b0;
      end
    end
  end

endmodule

/* tests/noc_mesh_checker.sv */
`include "noc_defines.svh"

module noc_mesh_checker import noc_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input logic [`NOC_NODES-1:0] nic_out_send,
  input logic [`NOC_NODES-1:0] nic_out_ready,
  input flit_t                 nic_out_flit [`NOC_NODES]
);

  int unsigned assert_fails = 0;  // Failure count

  // All output registers start empty
  a_idle_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> (nic_out_send == '0)
  ) else begin
    $error("nic_out_send high in the first cycle after reset");
    assert_fails++;
  end

  for (genvar n = 0; n < `NOC_NODES; n++) begin : g_node
    a_send_needs_ready: assert property (
      @(posedge clk) disable iff (!rst_n) nic_out_send[n] |-> nic_out_ready[n]
    ) else begin
      $error("node %0d sent while nic_out_ready was low", n);
      assert_fails++;
    end

    // Ejected flit must be addressed to this node
    a_dst_matches: assert property (
      @(posedge clk) disable iff (!rst_n)
        nic_out_send[n] |-> ((int'(nic_out_flit[n].dst_y) * `NOC_MESH_X
                              + int'(nic_out_flit[n].dst_x)) == n)
    ) else begin
      $error("node %0d ejected a flit for another node", n);
      assert_fails++;
    end
  end

endmodule

/* tests/noc_mesh_tb.sv */
`include "noc_defines.svh"

module noc_mesh_tb import noc_pkg::*; ();

  localparam int          total_flits = 16 + 2 + 200 + 200 + 80;
  localparam int          cycle_limit = 40 * total_flits + 200;
  localparam logic [31:0] seed        = 32'hbfaa;

  logic                  clk;
  logic                  rst_n;
  logic [`NOC_NODES-1:0] nic_in_send;
  flit_t                 nic_in_flit  [`NOC_NODES];
  logic [`NOC_NODES-1:0] nic_in_ready;
  logic [`NOC_NODES-1:0] nic_out_send;
  flit_t                 nic_out_flit [`NOC_NODES];
  logic [`NOC_NODES-1:0] nic_out_ready;

  flit_t tx_q  [`NOC_NODES][$];              // Flits waiting at each source NIC
  flit_t exp_q [`NOC_NODES][`NOC_NODES][$];  // Indexed by source and then destination

  logic [31:0] traffic_rng;
  logic [31:0] ready_rng;
  logic        backpressure;
  int          outstanding;  // Queued but not yet ejected
  int          errors;
  int          cycles;
  int          tests_passed;
  int          tests_failed;
  int          test_num;

  noc_mesh dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .nic_in_send   (nic_in_send),
    .nic_in_flit   (nic_in_flit),
    .nic_in_ready  (nic_in_ready),
    .nic_out_send  (nic_out_send),
    .nic_out_flit  (nic_out_flit),
    .nic_out_ready (nic_out_ready)
  );

  bind noc_mesh noc_mesh_checker checker_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .nic_out_send  (nic_out_send),
    .nic_out_ready (nic_out_ready),
    .nic_out_flit  (nic_out_flit)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    traffic_rng = lcg(traffic_rng);
    return traffic_rng;
  endfunction

  function automatic logic [payload_w-1:0] rand_payload();
    logic [63:0] w;
    w[63:32] = rand32();
    w[31:0]  = rand32();
    return w[payload_w-1:0];
  endfunction

  // Node index where a flit must leave the mesh
  function automatic int expected_node(input flit_t f);
    return int'(f.dst_y) * `NOC_MESH_X + int'(f.dst_x);
  endfunction

  function automatic int total_errors();
    return errors + int'(dut_i.checker_i.assert_fails);
  endfunction

  task automatic queue_flit(input int src, input int dst, input logic [payload_w-1:0] payload);
    flit_t f;
    f.dst_x   = coord_t'(dst % `NOC_MESH_X);
    f.dst_y   = coord_t'(dst / `NOC_MESH_X);
    f.src_x   = coord_t'(src % `NOC_MESH_X);
    f.src_y   = coord_t'(src / `NOC_MESH_X);
    f.payload = payload;
    exp_q[src][expected_node(f)].push_back(f);
    tx_q[src].push_back(f);
    outstanding++;
  endtask

  task automatic random_traffic(input int count);
    logic [31:0] r;
    int          src;
    int          dst;
    for (int i = 0; i < count; i++) begin
      r   = rand32();
      src = int'(r[31:28]);
      r   = rand32();
      dst = int'(r[31:28]);
      queue_flit(src, dst, rand_payload());
    end
  endtask

  task automatic wait_drain();
    while (outstanding != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);  // Checker sees the last sends
  endtask

  task automatic finish_test(input string name, input int err_start);
    test_num++;
    if (total_errors() == err_start) begin
      tests_passed++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", test_num, name, total_errors() - err_start);
    end
  endtask

  task automatic check_arrival(input int node, input flit_t got);
    int    src;
    flit_t want;
    src = int'(got.src_y) * `NOC_MESH_X + int'(got.src_x);
    if (exp_q[src][node].size() == 0) begin
      $display("node %0d received a flit from node %0d that nobody sent there", node, src);
      errors++;
    end else begin
      want = exp_q[src][node].pop_front();
      outstanding--;
      if (got !== want) begin
        $display("MISMATCH nic_out_flit[%0d]: got %h expected %h", node, got, want);
        errors++;
      end
    end
  endtask

  task automatic check_leftovers();
    for (int s = 0; s < `NOC_NODES; s++) begin
      for (int d = 0; d < `NOC_NODES; d++) begin
        if (exp_q[s][d].size() != 0) begin
          $display("%0d flits from node %0d to node %0d never arrived",
                   exp_q[s][d].size(), s, d);
          errors++;
        end
      end
    end
  endtask

  // Source NICs send one flit per pulse and only while ready
  always @(posedge clk) begin
    for (int n = 0; n < `NOC_NODES; n++) begin
      if (!rst_n) begin
        nic_in_send[n] <= 1'b0;
      end else if (nic_in_send[n]) begin
        nic_in_send[n] <= 1'b0;  // Accepted at this edge
      end else if (nic_in_ready[n] && tx_q[n].size() != 0) begin
        nic_in_flit[n] <= tx_q[n].pop_front();
        nic_in_send[n] <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    ready_rng <= lcg(ready_rng);
    if (!rst_n || !backpressure) begin
      nic_out_ready <= '1;
    end else begin
      nic_out_ready <= ready_rng[31:16];  // Roughly half the sinks stall
    end
  end

  // Scoreboard
  always @(posedge clk) begin
    if (rst_n) begin
      for (int n = 0; n < `NOC_NODES; n++) begin
        if (nic_out_send[n]) begin
          check_arrival(n, nic_out_flit[n]);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d flits still in flight", cycles, outstanding);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    int err_start;
    int hot_src [4];
    clk           = 1'b0;
    rst_n         = 1'b0;
    nic_in_send   = '0;
    nic_out_ready = '1;
    for (int n = 0; n < `NOC_NODES; n++) begin
      nic_in_flit[n] = '0;
    end
    traffic_rng  = seed;
    ready_rng    = lcg(seed);
    backpressure = 1'b0;
    outstanding  = 0;
    errors       = 0;
    cycles       = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_num     = 0;
    hot_src      = '{0, 3, 12, 15};
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    err_start = total_errors();
    // Every input buffer is empty once reset is released
    if (nic_in_ready !== {`NOC_NODES{1'b1}}) begin
      $display("MISMATCH nic_in_ready: got %h expected %h", nic_in_ready,
               {`NOC_NODES{1'b1}});
      errors++;
    end
    for (int n = 0; n < `NOC_NODES; n++) begin
      queue_flit(n, n, rand_payload());
    end
    wait_drain();
    finish_test("self delivery", err_start);

    err_start = total_errors();
    queue_flit(0, 15, rand_payload());
    queue_flit(15, 0, rand_payload());
    wait_drain();
    finish_test("corner to corner", err_start);

    err_start = total_errors();
    random_traffic(200);
    wait_drain();
    finish_test("random all-to-all", err_start);

    err_start    = total_errors();
    backpressure = 1'b1;
    random_traffic(200);
    wait_drain();
    backpressure = 1'b0;
    finish_test("back-pressure", err_start);

    // Four corners hammer node 5 and the payload carries source and sequence number
    err_start = total_errors();
    for (int seq = 0; seq < 20; seq++) begin
      for (int k = 0; k < 4; k++) begin
        queue_flit(hot_src[k], 5, payload_w'(hot_src[k] * 256 + seq));
      end
    end
    wait_drain();
    finish_test("ordering and contention", err_start);

    check_leftovers();
    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* noc_mesh.f */
+incdir+rtl
rtl/noc_pkg.sv
rtl/noc_input_port.sv
rtl/noc_output_port.sv
rtl/noc_router.sv
rtl/noc_mesh.sv
tests/noc_mesh_checker.sv
tests/noc_mesh_tb.sv

/* Bender.yml */
package:
  name: noc_mesh

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/noc_pkg.sv
      - rtl/noc_input_port.sv
      - rtl/noc_output_port.sv
      - rtl/noc_router.sv
      - rtl/noc_mesh.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - tests/noc_mesh_checker.sv
      - tests/noc_mesh_tb.sv
